//--- dcache_lite.f
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_array.sv
hw/dcache_tag_lookup.sv
hw/dcache_data_store.sv
hw/dcache_miss_ctrl.sv
hw/dcache_top.sv
tb/tb_dcache_top.sv

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_dcache_top \
  -f dcache_lite.f --Mdir "$BUILD_DIR" -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_dcache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0

//--- tb/dcache_cases.txt
// store size addr wdata expected, all hex
// size 0 b, 1 h, 2 w, 4 bu, 5 hu; expected is ignored for stores
0 2 00000100 00000000 C0DE0100
0 2 00000104 00000000 C0DE0104
0 2 00000108 00000000 C0DE0108
0 2 0000010C 00000000 C0DE010C
0 0 0000010C 00000000 0000000C
0 0 0000010D 00000000 00000001
0 0 0000010E 00000000 FFFFFFDE
0 0 0000010F 00000000 FFFFFFC0
0 4 0000010E 00000000 000000DE
0 4 0000010F 00000000 000000C0
0 1 0000010C 00000000 0000010C
0 1 0000010E 00000000 FFFFC0DE
0 5 0000010E 00000000 0000C0DE
0 5 0000010C 00000000 0000010C
0 0 000001F8 00000000 FFFFFFF8
0 4 000001F9 00000000 00000001
0 4 000001F8 00000000 000000F8
1 0 00000105 000000AA 00000000
0 2 00000104 00000000 C0DEAA04
1 1 0000010A 00001234 00000000
0 2 00000108 00000000 12340108
1 2 00000100 DEADBEEF 00000000
0 5 00000102 00000000 0000DEAD
1 1 00000212 0000BEEF 00000000
0 2 00000210 00000000 BEEF0210
1 2 00000204 11111111 00000000
0 2 00000300 00000000 C0DE0300
0 2 00000100 00000000 DEADBEEF
0 2 00000104 00000000 C0DEAA04
0 2 00000108 00000000 12340108
0 2 00000204 00000000 11111111
0 4 00000207 00000000 00000011
0 2 00000214 00000000 C0DE0214

//--- tb/tb_dcache_top.sv
/*
 * data cache testbench
 * plays load/store cases from a file against a word memory with
 * random stalls and read delays, checks load data, refill reads
 * and the words of every write-back
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

  localparam int NUM_SETS   = 16;
  localparam int LINE_WORDS = 4;
  localparam int LINE_SH    = $clog2(LINE_WORDS) + 2;
  localparam int MAX_CASES  = 64;
  localparam int MEM_WORDS  = 1024;
  localparam int MEM_LINES  = MEM_WORDS / LINE_WORDS;

  logic                       clk;
  logic                       rst_n;
  dcache_bus_pkg::cache_req_t req_i;
  logic                       req_ready_o;
  dcache_bus_pkg::cache_rsp_t rsp_o;
  logic                       rsp_ready_i;
  dcache_bus_pkg::mem_req_t   mem_req_o;
  logic                       mem_req_ready_i;
  dcache_bus_pkg::mem_rsp_t   mem_rsp_i;

  logic        c_store [MAX_CASES];
  logic [2:0]  c_size  [MAX_CASES];
  logic [31:0] c_addr  [MAX_CASES];
  logic [31:0] c_wdata [MAX_CASES];
  logic [31:0] c_exp   [MAX_CASES];
  logic [31:0] mem     [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] last_line [NUM_SETS];
  logic        visited [MEM_LINES];

  int          n_cases;
  int          req_idx;
  int          rsp_idx;
  int          errors;
  int          gap_cnt;
  int          rd_count;
  int          rd_total;
  int          wr_total;
  int          wb_cnt;
  int          rd_delay;
  logic        rd_pend;
  logic [31:0] rd_data;
  logic [31:0] wb_line;
  logic [15:0] lfsr;

  dcache_top #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) i_dcache_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .rsp_o           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i)
  );

  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[2:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("error: %s", what);
    errors++;
  endtask

  // little endian byte merge into the reference image
  task automatic apply_store(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
    int nbytes;
    nbytes = (size == dcache_cfg_pkg::SZ_W) ? 4 : (size == dcache_cfg_pkg::SZ_H) ? 2 : 1;
    for (int b = 0; b < nbytes; b++) begin
      ref_mem[addr[11:2]][8*(int'(addr[1:0]) + b) +: 8] = data[8*b +: 8];
    end
  endtask

  // ==========================================================================
  // memory model with one read outstanding
  // ==========================================================================
  task automatic memory_model();
    logic [3:0]  r;
    logic [31:0] a;
    logic [31:0] cur_line;
    cur_line = (rsp_idx < n_cases) ? c_addr[rsp_idx] >> LINE_SH : '1;
    mem_rsp_i.valid <= 1'b0;
    if (rd_pend) begin
      if (rd_delay == 0) begin
        mem_rsp_i.valid <= 1'b1;
        mem_rsp_i.rdata <= rd_data;
        rd_pend = 1'b0;
      end else begin
        rd_delay--;
      end
    end
    if (mem_req_o.valid && mem_req_ready_i) begin
      a = mem_req_o.addr;
      if (a >= MEM_WORDS * 4) begin
        report_error("memory access outside the model range");
      end else if (mem_req_o.we) begin
        if (wb_cnt == 0) begin
          wb_line = a >> LINE_SH;
          if (wb_line == cur_line) begin
            report_error("write-back of the line being requested");
          end
          // two ways, so the victim is never the line used last in its set
          if (wb_line == last_line[wb_line % NUM_SETS]) begin
            report_error("write-back of the most recently used line of its set");
          end
        end else if ((a >> LINE_SH) != wb_line) begin
          report_error("memory write outside the evicted line");
        end
        check_value("mem_req_o.wdata", mem_req_o.wdata, ref_mem[a[11:2]]);
        mem[a[11:2]] = mem_req_o.wdata;
        wb_cnt = (wb_cnt + 1) % LINE_WORDS;
        wr_total++;
      end else begin
        if (rd_pend) begin
          report_error("second memory read while one is outstanding");
        end
        if ((a >> LINE_SH) != cur_line) begin
          report_error("memory read outside the missed line");
        end
        take_bits(2, r);
        rd_delay = r[1:0];
        rd_data  = mem[a[11:2]];
        rd_pend  = 1'b1;
        rd_count++;
        rd_total++;
      end
    end
    take_bits(2, r);
    mem_req_ready_i <= (r[1:0] != 2'b00);
  endtask

  task automatic response_check();
    logic [3:0]  r;
    logic [31:0] rsp_line;
    if (rsp_o.valid && rsp_ready_i) begin
      if (rsp_idx >= req_idx) begin
        report_error("response with no request outstanding");
      end else begin
        rsp_line = c_addr[rsp_idx] >> LINE_SH;
        if (c_store[rsp_idx]) begin
          apply_store(c_addr[rsp_idx], c_size[rsp_idx], c_wdata[rsp_idx]);
        end else begin
          check_value($sformatf("rsp_o.rdata (case %0d)", rsp_idx), rsp_o.rdata,
                      c_exp[rsp_idx]);
        end
        if (rd_count != 0 && rd_count != LINE_WORDS) begin
          report_error($sformatf("case %0d saw %0d refill reads", rsp_idx, rd_count));
        end
        // a line never touched before has to come from memory
        if (rsp_line < MEM_LINES && !visited[rsp_line] && rd_count == 0) begin
          report_error($sformatf("case %0d hit on a line never loaded", rsp_idx));
        end
        // the line used by the previous case must still be present
        if (rsp_idx > 0 && rd_count != 0 &&
            (c_addr[rsp_idx] >> LINE_SH) == (c_addr[rsp_idx-1] >> LINE_SH)) begin
          report_error($sformatf("case %0d read memory on a hit", rsp_idx));
        end
        if (rsp_line < MEM_LINES) begin
          visited[rsp_line] = 1'b1;
        end
        last_line[rsp_line % NUM_SETS] = rsp_line;
        rd_count = 0;
        rsp_idx++;
      end
    end
    take_bits(2, r);
    rsp_ready_i <= (r[1:0] != 2'b00);
  endtask

  task automatic request_drive();
    logic [3:0] r;
    if (req_i.valid && req_ready_o) begin
      req_idx++;
      take_bits(2, r);
      gap_cnt = (r[1:0] == 2'b00) ? 2 : 0;
    end
    // payload holds until the transfer
    if (!req_i.valid || req_ready_o) begin
      if (gap_cnt > 0 || req_idx >= n_cases) begin
        req_i.valid <= 1'b0;
        gap_cnt = (gap_cnt > 0) ? gap_cnt - 1 : 0;
      end else begin
        req_i.valid <= 1'b1;
        req_i.store <= c_store[req_idx];
        req_i.size  <= dcache_cfg_pkg::size_e'(c_size[req_idx]);
        req_i.addr  <= c_addr[req_idx];
        req_i.wdata <= c_wdata[req_idx];
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      memory_model();
      response_check();
      request_drive();
    end
  end

  // ==========================================================================
  // case file, reset and end of run
  // ==========================================================================
  initial begin
    int          fd;
    int          limit;
    int          waited;
    string       line;
    logic [31:0] f_store;
    logic [31:0] f_size;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_exp;
    clk             = 1'b0;
    rst_n           = 1'b0;
    req_i           = '0;
    rsp_ready_i     = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rsp_i       = '0;
    lfsr            = 16'd16;
    n_cases         = 0;
    req_idx         = 0;
    rsp_idx         = 0;
    errors          = 0;
    gap_cnt         = 0;
    rd_count        = 0;
    rd_total        = 0;
    wr_total        = 0;
    wb_cnt          = 0;
    rd_delay        = 0;
    rd_pend         = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = (i * 4) ^ 32'hC0DE0000;
      ref_mem[i] = mem[i];
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      last_line[s] = '1;
    end
    for (int i = 0; i < MEM_LINES; i++) begin
      visited[i] = 1'b0;
    end
    fd = $fopen("tb/dcache_cases.txt", "r");
    if (fd == 0) begin
      report_error("cannot open tb/dcache_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (n_cases < MAX_CASES &&
            $sscanf(line, "%h %h %h %h %h", f_store, f_size, f_addr, f_wdata, f_exp) == 5) begin
          c_store[n_cases] = f_store[0];
          c_size[n_cases]  = f_size[2:0];
          c_addr[n_cases]  = f_addr;
          c_wdata[n_cases] = f_wdata;
          c_exp[n_cases]   = f_exp;
          n_cases++;
        end
      end
      $fclose(fd);
    end
    limit = n_cases * 300;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    waited = 0;
    while (rsp_idx < n_cases && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (rsp_idx < n_cases) begin
      report_error($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                             waited, rsp_idx, n_cases));
    end
    if (wr_total == 0 || wr_total % LINE_WORDS != 0) begin
      report_error("no complete write-back burst reached memory");
    end
    $display("cases: %0d  errors: %0d  mem reads: %0d  mem writes: %0d",
             n_cases, errors, rd_total, wr_total);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
/*
 * 2-way set-associative write-back data cache
 * load/store port towards the core, word-wide memory bus outwards
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dcache_bus_pkg::cache_req_t req_i,
  output logic                       req_ready_o,
  output dcache_bus_pkg::cache_rsp_t rsp_o,
  input  logic                       rsp_ready_i,
  output dcache_bus_pkg::mem_req_t   mem_req_o,
  input  logic                       mem_req_ready_i,
  input  dcache_bus_pkg::mem_rsp_t   mem_rsp_i
);

  localparam int WORD_W = dcache_cfg_pkg::WORD_W;
  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int LK_W   = dcache_cfg_pkg::ADDR_W - IDX_W - 2;

  logic [IDX_W-1:0]                  rd_index;
  logic [IDX_W-1:0]                  wr_index;
  logic [LK_W-1:0]                   lookup_tag;
  logic [LK_W-1:0]                   victim_tag;
  logic                              hit;
  logic                              hit_way;
  logic                              victim_way;
  logic                              victim_dirty;
  logic                              store_we;
  logic                              refill_we;
  logic                              way;
  logic                              fill_dirty;
  logic [$clog2(LINE_WORDS)+1:0]     offset;
  dcache_cfg_pkg::size_e             size;
  logic [WORD_W-1:0]                 store_data;
  logic [LINE_WORDS-1:0][WORD_W-1:0] refill_line;
  logic [dcache_cfg_pkg::NUM_WAYS-1:0][LINE_WORDS-1:0][WORD_W-1:0] lines;

  dcache_miss_ctrl #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) i_miss_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .rsp_o           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_i    (victim_way),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .lines_i         (lines),
    .rd_index_o      (rd_index),
    .lookup_tag_o    (lookup_tag),
    .store_we_o      (store_we),
    .refill_we_o     (refill_we),
    .way_o           (way),
    .wr_index_o      (wr_index),
    .fill_dirty_o    (fill_dirty),
    .offset_o        (offset),
    .size_o          (size),
    .store_data_o    (store_data),
    .refill_line_o   (refill_line)
  );

  // the refill tag is the tag being looked up
  dcache_tag_lookup #(
    .NUM_SETS (NUM_SETS)
  ) i_tag_lookup (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_index_i     (rd_index),
    .lookup_tag_i   (lookup_tag),
    .fill_we_i      (refill_we),
    .store_we_i     (store_we),
    .way_i          (way),
    .wr_index_i     (wr_index),
    .fill_tag_i     (lookup_tag),
    .fill_dirty_i   (fill_dirty),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag)
  );

  dcache_data_store #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) i_data_store (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_index_i    (rd_index),
    .store_we_i    (store_we),
    .refill_we_i   (refill_we),
    .way_i         (way),
    .wr_index_i    (wr_index),
    .offset_i      (offset),
    .size_i        (size),
    .store_data_i  (store_data),
    .refill_line_i (refill_line),
    .lines_o       (lines)
  );

endmodule

`default_nettype wire

//--- hw/dcache_miss_ctrl.sv
/*
 * data cache controller
 * holds the request stage, forms the load/store response on a hit
 * and runs write-back of a dirty victim, line refill and replay on
 * a miss over the word-wide memory bus
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl #(
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // core side
  input  dcache_bus_pkg::cache_req_t             req_i,
  output logic                                   req_ready_o,
  output dcache_bus_pkg::cache_rsp_t             rsp_o,
  input  logic                                   rsp_ready_i,
  // memory side
  output dcache_bus_pkg::mem_req_t               mem_req_o,
  input  logic                                   mem_req_ready_i,
  input  dcache_bus_pkg::mem_rsp_t               mem_rsp_i,
  // from tag lookup and data store
  input  logic                                   hit_i,
  input  logic                                   hit_way_i,
  input  logic                                   victim_way_i,
  input  logic                                   victim_dirty_i,
  input  logic [dcache_cfg_pkg::ADDR_W-$clog2(NUM_SETS)-3:0] victim_tag_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0][LINE_WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0]
                                                 lines_i,
  // write controls to both
  output logic [$clog2(NUM_SETS)-1:0]            rd_index_o,
  output logic [dcache_cfg_pkg::ADDR_W-$clog2(NUM_SETS)-3:0] lookup_tag_o,
  output logic                                   store_we_o,
  output logic                                   refill_we_o,
  output logic                                   way_o,
  output logic [$clog2(NUM_SETS)-1:0]            wr_index_o,
  output logic                                   fill_dirty_o,
  output logic [$clog2(LINE_WORDS)+1:0]          offset_o,
  output dcache_cfg_pkg::size_e                  size_o,
  output logic [dcache_cfg_pkg::WORD_W-1:0]      store_data_o,
  output logic [LINE_WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0] refill_line_o
);

  localparam int WORD_W = dcache_cfg_pkg::WORD_W;
  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int CNT_W  = $clog2(LINE_WORDS);
  localparam int OFF_W  = CNT_W + 2;
  localparam int TAG_W  = dcache_cfg_pkg::ADDR_W - IDX_W - OFF_W;
  localparam int LK_W   = dcache_cfg_pkg::ADDR_W - IDX_W - 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WB,
    ST_REFILL,
    ST_REPLAY
  } state_e;

  state_e                          state_q;
  logic                            armed_q;
  logic                            s_valid_q;
  dcache_bus_pkg::cache_req_t      s_req_q;
  logic [CNT_W-1:0]                cnt_q;
  logic                            pend_q;
  logic [LINE_WORDS-1:0][WORD_W-1:0] rbuf_q;

  logic                            rsp_fire;
  logic                            mem_fire;
  logic                            rsp_take;
  logic                            last_word;
  logic [TAG_W-1:0]                s_tag;
  logic [IDX_W-1:0]                s_index;
  logic [WORD_W-1:0]               hit_word;
  logic [WORD_W-1:0]               shifted;

  assign s_tag   = s_req_q.addr[dcache_cfg_pkg::ADDR_W-1 -: TAG_W];
  assign s_index = s_req_q.addr[OFF_W +: IDX_W];

  // ==========================================================================
  // request stage and response
  // ==========================================================================
  // the stage frees up when its response leaves
  assign req_ready_o = armed_q & (state_q == ST_IDLE) &
                       (~s_valid_q | (hit_i & rsp_ready_i));
  assign rsp_fire    = rsp_o.valid & rsp_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q   <= 1'b0;
      s_valid_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      if (req_ready_o) begin
        s_valid_q <= req_i.valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o) begin
      s_req_q <= req_i;
    end
  end

  // pick the word, then byte or halfword with extension
  always_comb begin
    hit_word    = lines_i[hit_way_i][s_req_q.addr[OFF_W-1:2]];
    shifted     = hit_word >> {s_req_q.addr[1:0], 3'b000};
    rsp_o.valid = s_valid_q & hit_i & (state_q == ST_IDLE);
    case (s_req_q.size)
      dcache_cfg_pkg::SZ_B:  rsp_o.rdata = {{24{shifted[7]}}, shifted[7:0]};
      dcache_cfg_pkg::SZ_BU: rsp_o.rdata = {24'b0, shifted[7:0]};
      dcache_cfg_pkg::SZ_H:  rsp_o.rdata = {{16{shifted[15]}}, shifted[15:0]};
      dcache_cfg_pkg::SZ_HU: rsp_o.rdata = {16'b0, shifted[15:0]};
      default:               rsp_o.rdata = hit_word;
    endcase
  end

  // ==========================================================================
  // miss handling
  // ==========================================================================
  assign mem_fire  = mem_req_o.valid & mem_req_ready_i;
  assign rsp_take  = (state_q == ST_REFILL) & mem_rsp_i.valid;
  assign last_word = cnt_q == CNT_W'(LINE_WORDS - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (s_valid_q && !hit_i) begin
            state_q <= victim_dirty_i ? ST_WB : ST_REFILL;
          end
        end
        ST_WB: begin
          // counter wraps to zero for the refill
          if (mem_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= ST_REFILL;
            end
          end
        end
        ST_REFILL: begin
          if (mem_fire) begin
            pend_q <= 1'b1;
          end
          if (rsp_take) begin
            pend_q <= 1'b0;
            cnt_q  <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= ST_REPLAY;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_take) begin
      rbuf_q[cnt_q] <= mem_rsp_i.rdata;
    end
  end

  // write-back from the victim tag, refill from the request address
  always_comb begin
    mem_req_o.valid = (state_q == ST_WB) | ((state_q == ST_REFILL) & ~pend_q);
    mem_req_o.we    = state_q == ST_WB;
    mem_req_o.addr  = {(state_q == ST_WB) ? victim_tag_i[TAG_W-1:0] : s_tag,
                       s_index, cnt_q, 2'b00};
    mem_req_o.wdata = lines_i[victim_way_i][cnt_q];
  end

  // last word goes straight into the line
  always_comb begin
    for (int w = 0; w < LINE_WORDS; w++) begin
      refill_line_o[w] = (w == int'(cnt_q)) ? mem_rsp_i.rdata : rbuf_q[w];
    end
  end

  assign refill_we_o = rsp_take & last_word;
  assign store_we_o  = s_req_q.store & (rsp_fire | refill_we_o);

  assign rd_index_o   = req_ready_o ? req_i.addr[OFF_W +: IDX_W] : s_index;
  assign lookup_tag_o = LK_W'(s_tag);
  assign way_o        = (state_q == ST_IDLE) ? hit_way_i : victim_way_i;
  assign wr_index_o   = s_index;
  assign fill_dirty_o = s_req_q.store;
  assign offset_o     = s_req_q.addr[OFF_W-1:0];
  assign size_o       = s_req_q.size;
  assign store_data_o = s_req_q.wdata;

endmodule

`default_nettype wire

//--- hw/dcache_data_store.sv
/*
 * data cache line storage
 * line arrays for both ways, byte merge of stores into the current
 * line and refill writes of a whole collected line
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store #(
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [$clog2(NUM_SETS)-1:0]            rd_index_i,
  input  logic                                   store_we_i,
  input  logic                                   refill_we_i,
  input  logic                                   way_i,
  input  logic [$clog2(NUM_SETS)-1:0]            wr_index_i,
  input  logic [$clog2(LINE_WORDS)+1:0]          offset_i,
  input  dcache_cfg_pkg::size_e                  size_i,
  input  logic [dcache_cfg_pkg::WORD_W-1:0]      store_data_i,
  input  logic [LINE_WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0] refill_line_i,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0][LINE_WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0]
                                                 lines_o
);

  localparam int NW = dcache_cfg_pkg::NUM_WAYS;

  typedef logic [LINE_WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0] line_t;

  line_t                           base_line;
  logic [LINE_WORDS*4-1:0][7:0]    merged;
  line_t                           wr_line;
  logic [2:0]                      nbytes;
  logic [NW-1:0]                   line_we;

  always_comb begin
    case (size_i)
      dcache_cfg_pkg::SZ_W: nbytes = 3'd4;
      dcache_cfg_pkg::SZ_H: nbytes = 3'd2;
      default:              nbytes = 3'd1;
    endcase
  end

  // refill line or current line, then the store bytes on top
  always_comb begin
    base_line = refill_we_i ? refill_line_i : lines_o[way_i];
    merged    = base_line;
    if (store_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (b < nbytes) begin
          merged[offset_i + b] = store_data_i[8*b +: 8];
        end
      end
    end
  end

  assign wr_line = merged;

  for (genvar w = 0; w < NW; w++) begin : g_way
    assign line_we[w] = (store_we_i | refill_we_i) & (way_i == 1'(w));

    dcache_array #(
      .payload_t (line_t),
      .DEPTH     (NUM_SETS)
    ) i_line_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (line_we[w]),
      .waddr_i (wr_index_i),
      .wdata_i (wr_line),
      .raddr_i (rd_index_i),
      .rdata_o (lines_o[w])
    );
  end

endmodule

`default_nettype wire

//--- hw/dcache_tag_lookup.sv
/*
 * data cache tag lookup
 * tag and meta arrays for both ways, per-set valid flops cleared
 * on reset, hit detection against the held request and the lru
 * bit that names the victim way
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_lookup #(
  parameter int NUM_SETS = 16
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic [$clog2(NUM_SETS)-1:0]                        rd_index_i,
  input  logic [dcache_cfg_pkg::ADDR_W-$clog2(NUM_SETS)-3:0] lookup_tag_i,
  input  logic                                               fill_we_i,
  input  logic                                               store_we_i,
  input  logic                                               way_i,
  input  logic [$clog2(NUM_SETS)-1:0]                        wr_index_i,
  input  logic [dcache_cfg_pkg::ADDR_W-$clog2(NUM_SETS)-3:0] fill_tag_i,
  input  logic                                               fill_dirty_i,
  output logic                                               hit_o,
  output logic                                               hit_way_o,
  output logic                                               victim_way_o,
  output logic                                               victim_dirty_o,
  output logic [dcache_cfg_pkg::ADDR_W-$clog2(NUM_SETS)-3:0] victim_tag_o
);

  localparam int NW    = dcache_cfg_pkg::NUM_WAYS;
  localparam int IDX_W = $clog2(NUM_SETS);
  // sized for one-word lines, upper bits stay zero for longer lines
  localparam int TAG_W = dcache_cfg_pkg::ADDR_W - IDX_W - 2;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    dcache_cfg_pkg::meta_t meta;
  } entry_t;

  entry_t                       entry_wdata;
  entry_t [NW-1:0]              entry_rd;
  logic [NW-1:0]                entry_we;
  logic [NW-1:0]                way_hit;
  logic [NW-1:0]                valid_rd_q;
  logic [NW-1:0][NUM_SETS-1:0]  valid_q;
  logic [NUM_SETS-1:0]          lru_q;
  logic [IDX_W-1:0]             rd_index_q;

  // store hit only sets dirty, refill brings in a fresh tag
  assign entry_wdata.tag        = fill_tag_i;
  assign entry_wdata.meta.valid = 1'b1;
  assign entry_wdata.meta.dirty = store_we_i | fill_dirty_i;

  for (genvar w = 0; w < NW; w++) begin : g_way
    assign entry_we[w] = (fill_we_i | store_we_i) & (way_i == 1'(w));

    dcache_array #(
      .payload_t (entry_t),
      .DEPTH     (NUM_SETS)
    ) i_tag_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (entry_we[w]),
      .waddr_i (wr_index_i),
      .wdata_i (entry_wdata),
      .raddr_i (rd_index_i),
      .rdata_o (entry_rd[w])
    );

    assign way_hit[w] = valid_rd_q[w] & entry_rd[w].meta.valid &
                        (entry_rd[w].tag == lookup_tag_i);
  end

  // ==========================================================================
  // valid flops and lru bits
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      valid_rd_q <= '0;
      rd_index_q <= '0;
      lru_q      <= '0;
    end else begin
      for (int w = 0; w < NW; w++) begin
        if (fill_we_i && entry_we[w]) begin
          valid_q[w][wr_index_i] <= 1'b1;
        end
        valid_rd_q[w] <= valid_q[w][rd_index_i] |
                         (fill_we_i & entry_we[w] & (wr_index_i == rd_index_i));
      end
      rd_index_q <= rd_index_i;
      // point away from the way just used
      if (fill_we_i || store_we_i) begin
        lru_q[wr_index_i] <= ~way_i;
      end else if (hit_o) begin
        lru_q[wr_index_i] <= ~hit_way_o;
      end
    end
  end

  // hit only counts when the read was for the held set
  assign hit_o     = (|way_hit) & (rd_index_q == wr_index_i);
  assign hit_way_o = way_hit[1];

  assign victim_way_o   = lru_q[wr_index_i];
  assign victim_dirty_o = valid_rd_q[victim_way_o] & entry_rd[victim_way_o].meta.dirty;
  assign victim_tag_o   = entry_rd[victim_way_o].tag;

endmodule

`default_nettype wire

//--- hw/dcache_array.sv
/*
 * cache storage array
 * one write port and one registered read port, a write to the
 * address being read shows up on the read side in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output payload_t                 rdata_o
);

  payload_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // write-first read register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- hw/dcache_bus_pkg.sv
/*
 * data cache bus types
 * load/store request and response seen by the core, and the
 * word-wide valid/ready memory bus with in-order read data
 */
`default_nettype none

package dcache_bus_pkg;

  // core request, payload holds until accepted
  typedef struct packed {
    logic                                valid;
    logic                                store;
    dcache_cfg_pkg::size_e               size;
    logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
    logic [dcache_cfg_pkg::WORD_W-1:0]   wdata;
  } cache_req_t;

  // one response per request, stores included
  typedef struct packed {
    logic                                valid;
    logic [dcache_cfg_pkg::WORD_W-1:0]   rdata;
  } cache_rsp_t;

  // memory request, addr is word aligned
  typedef struct packed {
    logic                                valid;
    logic                                we;
    logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
    logic [dcache_cfg_pkg::WORD_W-1:0]   wdata;
  } mem_req_t;

  // read return, no ready on this side
  typedef struct packed {
    logic                                valid;
    logic [dcache_cfg_pkg::WORD_W-1:0]   rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/dcache_cfg_pkg.sv
/*
 * data cache configuration
 * fixed geometry constants, load/store size codes and the per-line
 * meta bits kept next to each tag
 */
`default_nettype none

package dcache_cfg_pkg;

  // address and data word widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // two ways only, a single lru bit per set picks the victim
  localparam int NUM_WAYS = 2;

  // access size, loads use all five codes, stores only the signed ones
  typedef enum logic [2:0] {
    SZ_B  = 3'd0,
    SZ_H  = 3'd1,
    SZ_W  = 3'd2,
    SZ_BU = 3'd4,
    SZ_HU = 3'd5
  } size_e;

  // line state stored with the tag
  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

endpackage

`default_nettype wire
